// File: fu_cdb.f
verilog/fu_pkg.sv
verilog/alu_unit.sv
verilog/mult_unit.sv
verilog/cdb_arbiter.sv
verilog/fu_cdb.sv
testbench/fu_cdb_tb.sv

// File: Makefile
TOP = fu_cdb_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f fu_cdb.f --top-module fu_cdb

sim:
	verilator --binary --timing --assert -Wno-fatal -f fu_cdb.f \
		--top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/fu_cdb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fu_cdb_tb;

    localparam int MULT_STAGES = 3;

    // unit 0 is the multiplier, 1 and 2 are the ALUs
    typedef struct {
        int          unit;
        logic [2:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  tag;
        logic [31:0] exp;
    } entry_t;

    logic                  clock;
    logic                  rst_n;
    logic                  squash;
    logic [1:0]            alu_valid;
    fu_pkg::alu_op_e [1:0] alu_op;
    logic [1:0][31:0]      alu_a;
    logic [1:0][31:0]      alu_b;
    logic [1:0][5:0]       alu_tag;
    logic [1:0]            alu_avail;
    logic                  mult_valid;
    fu_pkg::mult_op_e      mult_op;
    logic [31:0]           mult_a;
    logic [31:0]           mult_b;
    logic [5:0]            mult_tag;
    logic                  mult_avail;
    logic [1:0]            cdb_valid;
    logic [1:0][5:0]       cdb_tag;
    logic [1:0][31:0]      cdb_value;

    // scoreboard by tag
    logic [63:0] pending;
    logic [63:0] delivered;
    logic [31:0] exp_val [64];
    logic [5:0]  arrival [$];

    entry_t vectors [13];
    int     seed = 92318;
    int     errors = 0;
    int     errors_before = 0;
    int     passed = 0;
    int     failed = 0;
    int     lat;
    time    t0;

    fu_cdb UUT (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return a << b[4:0];
            3'd6: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mult_ref(input logic hi, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0] p;
        p = 64'(a) * 64'(b);
        return hi ? p[63:32] : p[31:0];
    endfunction

    function automatic entry_t row(input int unit, input logic [2:0] op, input logic [31:0] a,
                                   input logic [31:0] b, input logic [5:0] tag,
                                   input logic [31:0] exp);
        entry_t r;
        r.unit = unit;
        r.op   = op;
        r.a    = a;
        r.b    = b;
        r.tag  = tag;
        r.exp  = exp;
        return r;
    endfunction

    function automatic logic unit_avail(input int u);
        return (u == 0) ? mult_avail : alu_avail[u-1];
    endfunction

    // drive one op, hold it until accepted, then record the expected result
    task automatic issue(input entry_t r);
        int n;
        if (r.unit == 0) begin
            mult_valid <= 1'b1;
            mult_op    <= fu_pkg::mult_op_e'(r.op[0]);
            mult_a     <= r.a;
            mult_b     <= r.b;
            mult_tag   <= r.tag;
        end else begin
            alu_valid[r.unit-1] <= 1'b1;
            alu_op[r.unit-1]    <= fu_pkg::alu_op_e'(r.op);
            alu_a[r.unit-1]     <= r.a;
            alu_b[r.unit-1]     <= r.b;
            alu_tag[r.unit-1]   <= r.tag;
        end
        n = 0;
        @(negedge clock);
        while (!unit_avail(r.unit) && n < 100) begin
            @(negedge clock);
            n++;
        end
        assert (n < 100) else begin
            $display("Error at %0t: unit %0d never became available", $time, r.unit);
            errors++;
        end
        @(posedge clock);
        exp_val[r.tag]   = r.exp;
        delivered[r.tag] = 1'b0;
        pending[r.tag]   = 1'b1;
    endtask

    task automatic release_unit(input int u);
        if (u == 0)
            mult_valid <= 1'b0;
        else
            alu_valid[u-1] <= 1'b0;
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (pending != '0 && cycles < 300) begin
            @(posedge clock);
            cycles++;
        end
        assert (pending == '0) else begin
            $display("Error at %0t: timeout waiting for tags %h", $time, pending);
            errors++;
        end
    endtask

    task automatic stream(input int unit, input int base);
        entry_t r;
        for (int i = 0; i < 40; i++) begin
            r.unit = unit;
            r.op   = (unit == 0) ? 3'($random(seed) & 1) : 3'($random(seed));
            r.a    = $random(seed);
            r.b    = $random(seed);
            r.tag  = 6'(base + i % 16);
            r.exp  = (unit == 0) ? mult_ref(r.op[0], r.a, r.b) : alu_ref(r.op, r.a, r.b);
            issue(r);
        end
        release_unit(unit);
    endtask

    task automatic report(input string name);
        if (errors == errors_before) begin
            $display("test %s: pass", name);
            passed++;
        end else begin
            $display("test %s: FAIL", name);
            failed++;
        end
        errors_before = errors;
    endtask

    always @(negedge clock) begin
        logic [5:0] t;
        if (rst_n) begin
            for (int k = 0; k < 2; k++) begin
                t = cdb_tag[k];
                if (cdb_valid[k]) begin
                    assert (pending[t]) else begin
                        if (delivered[t])
                            $display("Error at %0t: tag %0d seen on the CDB twice", $time, t);
                        else
                            $display("Error at %0t: unknown tag %0d on the CDB", $time, t);
                        errors++;
                    end
                    if (pending[t]) begin
                        assert (cdb_value[k] === exp_val[t]) else begin
                            $display("Mismatch at %0t: tag %0d port %0d got %h expected %h",
                                     $time, t, k, cdb_value[k], exp_val[t]);
                            errors++;
                        end
                        pending[t]   = 1'b0;
                        delivered[t] = 1'b1;
                        arrival.push_back(t);
                    end
                end
            end
        end
    end

    initial begin
        entry_t r;
        rst_n      = 1'b0;
        squash     = 1'b0;
        alu_valid  = '0;
        alu_op[0]  = fu_pkg::alu_add;
        alu_op[1]  = fu_pkg::alu_add;
        alu_a      = '0;
        alu_b      = '0;
        alu_tag    = '0;
        mult_valid = 1'b0;
        mult_op    = fu_pkg::mul_lo;
        mult_a     = '0;
        mult_b     = '0;
        mult_tag   = '0;
        pending    = '0;
        delivered  = '0;
        //                unit op    a              b              tag    expected
        vectors[0]  = row(1, 3'd0, 32'h0000_0005, 32'h0000_0003, 6'd1,  32'h0000_0008);
        vectors[1]  = row(2, 3'd1, 32'h0000_0005, 32'h0000_0007, 6'd2,  32'hffff_fffe);
        vectors[2]  = row(1, 3'd2, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 6'd3,  32'h00f0_00f0);
        vectors[3]  = row(2, 3'd3, 32'hf0f0_0000, 32'h0000_0f0f, 6'd4,  32'hf0f0_0f0f);
        vectors[4]  = row(1, 3'd4, 32'hffff_0000, 32'h0f0f_0f0f, 6'd5,  32'hf0f0_0f0f);
        vectors[5]  = row(2, 3'd5, 32'h0000_0001, 32'h0000_0024, 6'd6,  32'h0000_0010);
        vectors[6]  = row(1, 3'd6, 32'h8000_0000, 32'h0000_001f, 6'd7,  32'h0000_0001);
        vectors[7]  = row(2, 3'd7, 32'hffff_ffff, 32'h0000_0001, 6'd8,  32'h0000_0001);
        vectors[8]  = row(1, 3'd7, 32'h0000_0001, 32'hffff_ffff, 6'd9,  32'h0000_0000);
        vectors[9]  = row(0, 3'd0, 32'h0000_0003, 32'h0000_0005, 6'd10, 32'h0000_000f);
        vectors[10] = row(0, 3'd1, 32'hffff_ffff, 32'hffff_ffff, 6'd11, 32'hffff_fffe);
        vectors[11] = row(0, 3'd0, 32'hffff_ffff, 32'hffff_ffff, 6'd12, 32'h0000_0001);
        vectors[12] = row(0, 3'd1, 32'h0001_0000, 32'h0001_0000, 6'd13, 32'h0000_0001);

        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        assert (alu_avail == 2'b11 && mult_avail && cdb_valid == '0) else begin
            $display("Error at %0t: units not idle after reset", $time);
            errors++;
        end
        report("1 reset state");

        @(posedge clock);
        for (int i = 0; i < 9; i++) begin
            issue(vectors[i]);
            release_unit(vectors[i].unit);
            wait_idle(lat);
            assert (lat == 2) else begin
                $display("Error at %0t: tag %0d took %0d cycles", $time, vectors[i].tag, lat);
                errors++;
            end
        end
        report("2 alu opcodes");

        arrival.delete();
        t0 = $time;
        for (int i = 9; i < 13; i++)
            issue(vectors[i]);
        release_unit(0);
        assert ($time - t0 == 80) else begin
            $display("Error at %0t: multiplier stalled on back-to-back issue", $time);
            errors++;
        end
        wait_idle(lat);
        assert (arrival.size() == 4 && arrival[0] == 10 && arrival[1] == 11 &&
                arrival[2] == 12 && arrival[3] == 13) else begin
            $display("Error at %0t: multiplier results not in issue order", $time);
            errors++;
        end
        report("3 multiplier");

        // ALUs accepted so that all three finish together
        issue(vectors[9]);
        release_unit(0);
        repeat (MULT_STAGES - 2) @(posedge clock);
        fork
            issue(vectors[0]);
            issue(vectors[1]);
        join
        release_unit(1);
        release_unit(2);
        @(negedge clock);
        assert (alu_avail == 2'b01) else begin
            $display("Error at %0t: ALU 1 available while its result waits", $time);
            errors++;
        end
        @(negedge clock);
        assert (cdb_valid == 2'b11 && cdb_tag[0] == 6'd10 && cdb_tag[1] == 6'd1) else begin
            $display("Error at %0t: multiplier and ALU 0 did not win the bus", $time);
            errors++;
        end
        @(negedge clock);
        assert (cdb_valid == 2'b01 && cdb_tag[0] == 6'd2) else begin
            $display("Error at %0t: held ALU 1 result did not follow", $time);
            errors++;
        end
        @(posedge clock);
        wait_idle(lat);
        report("4 contention");

        fork
            stream(0, 0);
            stream(1, 16);
            stream(2, 32);
        join
        wait_idle(lat);
        report("5 random stream");

        r = vectors[9];
        r.tag = 6'd50;
        issue(r);
        r.tag = 6'd51;
        issue(r);
        release_unit(0);
        r = vectors[0];
        r.tag = 6'd52;
        issue(r);
        // new ALU op offered in the squash cycle
        alu_tag[0] <= 6'd53;
        squash     <= 1'b1;
        @(posedge clock);
        pending = '0;
        squash <= 1'b0;
        release_unit(1);
        @(negedge clock);
        assert (alu_avail == 2'b11 && mult_avail && cdb_valid == '0) else begin
            $display("Error at %0t: units not idle after squash", $time);
            errors++;
        end
        repeat (MULT_STAGES + 2) @(posedge clock);
        issue(vectors[9]);
        release_unit(0);
        issue(vectors[3]);
        release_unit(2);
        wait_idle(lat);
        report("6 squash");

        $display("tests passed %0d failed %0d", passed, failed);
        if (errors == 0 && failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fu_cdb.sv
`timescale 1ns/1ps
`default_nettype none

module fu_cdb #(
    parameter int XLEN        = 32,
    parameter int TAG_WIDTH   = 6,
    parameter int NUM_ALU     = 2,
    parameter int CDB_WIDTH   = 2,
    parameter int MULT_STAGES = 3
) (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire                                 squash,
    input  wire  [NUM_ALU-1:0]                  alu_valid,
    input  fu_pkg::alu_op_e [NUM_ALU-1:0]       alu_op,
    input  wire  [NUM_ALU-1:0][XLEN-1:0]        alu_a,
    input  wire  [NUM_ALU-1:0][XLEN-1:0]        alu_b,
    input  wire  [NUM_ALU-1:0][TAG_WIDTH-1:0]   alu_tag,
    output logic [NUM_ALU-1:0]                  alu_avail,
    input  wire                                 mult_valid,
    input  fu_pkg::mult_op_e                    mult_op,
    input  wire  [XLEN-1:0]                     mult_a,
    input  wire  [XLEN-1:0]                     mult_b,
    input  wire  [TAG_WIDTH-1:0]                mult_tag,
    output logic                                mult_avail,
    output logic [CDB_WIDTH-1:0]                cdb_valid,
    output logic [CDB_WIDTH-1:0][TAG_WIDTH-1:0] cdb_tag,
    output logic [CDB_WIDTH-1:0][XLEN-1:0]      cdb_value
);

    logic [NUM_ALU-1:0]                alu_done;
    logic [NUM_ALU-1:0][TAG_WIDTH-1:0] alu_done_tag;
    logic [NUM_ALU-1:0][XLEN-1:0]      alu_done_value;
    logic [NUM_ALU-1:0]                alu_grant;

    logic                 mult_done;
    logic [TAG_WIDTH-1:0] mult_done_tag;
    logic [XLEN-1:0]      mult_done_value;
    logic                 mult_grant;

    for (genvar i = 0; i < NUM_ALU; i++) begin : g_alu
        alu_unit #(
            .XLEN      (XLEN),
            .TAG_WIDTH (TAG_WIDTH)
        ) u_alu (
            .clock      (clock),
            .rst_n      (rst_n),
            .squash     (squash),
            .valid      (alu_valid[i]),
            .op         (alu_op[i]),
            .a          (alu_a[i]),
            .b          (alu_b[i]),
            .tag        (alu_tag[i]),
            .grant      (alu_grant[i]),
            .avail      (alu_avail[i]),
            .done       (alu_done[i]),
            .done_tag   (alu_done_tag[i]),
            .done_value (alu_done_value[i])
        );
    end

    mult_unit #(
        .XLEN        (XLEN),
        .TAG_WIDTH   (TAG_WIDTH),
        .MULT_STAGES (MULT_STAGES)
    ) u_mult (
        .clock      (clock),
        .rst_n      (rst_n),
        .squash     (squash),
        .valid      (mult_valid),
        .op         (mult_op),
        .a          (mult_a),
        .b          (mult_b),
        .tag        (mult_tag),
        .grant      (mult_grant),
        .avail      (mult_avail),
        .done       (mult_done),
        .done_tag   (mult_done_tag),
        .done_value (mult_done_value)
    );

    cdb_arbiter #(
        .XLEN      (XLEN),
        .TAG_WIDTH (TAG_WIDTH),
        .NUM_ALU   (NUM_ALU),
        .CDB_WIDTH (CDB_WIDTH)
    ) u_arb (
        .clock           (clock),
        .rst_n           (rst_n),
        .squash          (squash),
        .alu_done        (alu_done),
        .alu_done_tag    (alu_done_tag),
        .alu_done_value  (alu_done_value),
        .mult_done       (mult_done),
        .mult_done_tag   (mult_done_tag),
        .mult_done_value (mult_done_value),
        .alu_grant       (alu_grant),
        .mult_grant      (mult_grant),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value)
    );

endmodule

`default_nettype wire

// File: verilog/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
    parameter int XLEN      = 32,
    parameter int TAG_WIDTH = 6,
    parameter int NUM_ALU   = 2,
    parameter int CDB_WIDTH = 2
) (
    input  wire                                  clock,
    input  wire                                  rst_n,
    input  wire                                  squash,
    input  wire  [NUM_ALU-1:0]                   alu_done,
    input  wire  [NUM_ALU-1:0][TAG_WIDTH-1:0]    alu_done_tag,
    input  wire  [NUM_ALU-1:0][XLEN-1:0]         alu_done_value,
    input  wire                                  mult_done,
    input  wire  [TAG_WIDTH-1:0]                 mult_done_tag,
    input  wire  [XLEN-1:0]                      mult_done_value,
    output logic [NUM_ALU-1:0]                   alu_grant,
    output logic                                 mult_grant,
    output logic [CDB_WIDTH-1:0]                 cdb_valid,
    output logic [CDB_WIDTH-1:0][TAG_WIDTH-1:0]  cdb_tag,
    output logic [CDB_WIDTH-1:0][XLEN-1:0]       cdb_value
);

    localparam int NUM_REQ = NUM_ALU + 1;

    // requester 0 is the multiplier, then ALU 0, ALU 1 ...
    logic [NUM_REQ-1:0]                req;
    logic [NUM_REQ-1:0][TAG_WIDTH-1:0] req_tag;
    logic [NUM_REQ-1:0][XLEN-1:0]      req_value;
    logic [NUM_REQ-1:0]                gnt;

    logic [CDB_WIDTH-1:0]                sel_valid;
    logic [CDB_WIDTH-1:0][TAG_WIDTH-1:0] sel_tag;
    logic [CDB_WIDTH-1:0][XLEN-1:0]      sel_value;

    assign req       = {alu_done, mult_done};
    assign req_tag   = {alu_done_tag, mult_done_tag};
    assign req_value = {alu_done_value, mult_done_value};

    assign mult_grant = gnt[0];
    assign alu_grant  = gnt[NUM_REQ-1:1];

    always_comb begin
        int cnt;
        cnt       = 0;
        gnt       = '0;
        sel_valid = '0;
        sel_tag   = '0;
        sel_value = '0;
        // fixed priority walk, packed into the lowest free port
        for (int r = 0; r < NUM_REQ; r++) begin
            if (req[r] && cnt < CDB_WIDTH) begin
                gnt[r]         = 1'b1;
                sel_valid[cnt] = 1'b1;
                sel_tag[cnt]   = req_tag[r];
                sel_value[cnt] = req_value[r];
                cnt            = cnt + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            cdb_valid <= '0;
        end else begin
            cdb_valid <= sel_valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= sel_tag;
        cdb_value <= sel_value;
    end

endmodule

`default_nettype wire

// File: verilog/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mult_unit #(
    parameter int XLEN        = 32,
    parameter int TAG_WIDTH   = 6,
    parameter int MULT_STAGES = 3
) (
    input  wire                  clock,
    input  wire                  rst_n,
    input  wire                  squash,
    input  wire                  valid,
    input  fu_pkg::mult_op_e     op,
    input  wire [XLEN-1:0]       a,
    input  wire [XLEN-1:0]       b,
    input  wire [TAG_WIDTH-1:0]  tag,
    input  wire                  grant,
    output logic                 avail,
    output logic                 done,
    output logic [TAG_WIDTH-1:0] done_tag,
    output logic [XLEN-1:0]      done_value
);

    localparam int LAST = MULT_STAGES - 1;

    logic [MULT_STAGES-1:0] stage_valid;
    logic [TAG_WIDTH-1:0]   stage_tag  [MULT_STAGES];
    fu_pkg::mult_op_e       stage_op   [MULT_STAGES];
    logic [2*XLEN-1:0]      stage_prod [MULT_STAGES];

    logic [2*XLEN-1:0] full_prod;
    logic              advance;

    // whole pipe moves only if the last stage drains
    assign advance = !stage_valid[LAST] || grant;
    assign avail   = advance;

    assign full_prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};

    assign done     = stage_valid[LAST];
    assign done_tag = stage_tag[LAST];

    always_comb begin
        if (stage_op[LAST] == fu_pkg::mul_hi) begin
            done_value = stage_prod[LAST][2*XLEN-1:XLEN];
        end else begin
            done_value = stage_prod[LAST][XLEN-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid[0] <= valid;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // product formed in stage 0, carried down unchanged
    always_ff @(posedge clock) begin
        if (advance) begin
            stage_prod[0] <= full_prod;
            stage_tag[0]  <= tag;
            stage_op[0]   <= op;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage_prod[s] <= stage_prod[s-1];
                stage_tag[s]  <= stage_tag[s-1];
                stage_op[s]   <= stage_op[s-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter int XLEN      = 32,
    parameter int TAG_WIDTH = 6
) (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 squash,
    input  wire                 valid,
    input  fu_pkg::alu_op_e     op,
    input  wire [XLEN-1:0]      a,
    input  wire [XLEN-1:0]      b,
    input  wire [TAG_WIDTH-1:0] tag,
    input  wire                 grant,
    output logic                avail,
    output logic                done,
    output logic [TAG_WIDTH-1:0] done_tag,
    output logic [XLEN-1:0]     done_value
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic                 held;
    logic [TAG_WIDTH-1:0] tag_q;
    logic [XLEN-1:0]      value_q;
    logic [XLEN-1:0]      result;
    logic                 accept;

    // free when empty or when the bus takes the result this cycle
    assign avail  = !held || grant;
    assign accept = valid && avail;

    assign done       = held;
    assign done_tag   = tag_q;
    assign done_value = value_q;

    always_comb begin
        case (op)
            fu_pkg::alu_add: result = a + b;
            fu_pkg::alu_sub: result = a - b;
            fu_pkg::alu_and: result = a & b;
            fu_pkg::alu_or:  result = a | b;
            fu_pkg::alu_xor: result = a ^ b;
            fu_pkg::alu_sll: result = a << b[SHAMT_W-1:0];
            fu_pkg::alu_srl: result = a >> b[SHAMT_W-1:0];
            fu_pkg::alu_slt: result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (grant) begin
            held <= 1'b0;
        end
    end

    // holding register for result and tag
    always_ff @(posedge clock) begin
        if (accept) begin
            tag_q   <= tag;
            value_q <= result;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fu_pkg.sv
`default_nettype none

package fu_pkg;

    // integer ALU operations
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        // signed compare, result is 1 or 0
        alu_slt = 3'd7
    } alu_op_e;

    // which half of the unsigned product goes out
    typedef enum logic {
        mul_lo = 1'b0,
        mul_hi = 1'b1
    } mult_op_e;

endpackage

`default_nettype wire
